/* hw/cache_alt.sv */
// Two-way write-back data cache with flush
// Joins the controller and the datapath behind val/rdy processor and memory ports

`default_nettype none

module cache_alt
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_val,
  output logic  req_rdy,
  input  logic  req_write,
  input  addr_t req_addr,
  input  word_t req_data,
  output logic  resp_val,
  input  logic  resp_rdy,
  output logic  resp_write,
  output word_t resp_data,
  output logic  mem_req_val,
  input  logic  mem_req_rdy,
  output logic  mem_req_write,
  output addr_t mem_req_addr,
  output word_t mem_req_data,
  input  logic  mem_resp_val,
  output logic  mem_resp_rdy,
  input  word_t mem_resp_data,
  input  logic  flush,
  output logic  flush_done
);

  // Control
  logic  req_load;
  logic  tag_wen;
  logic  data_wen;
  logic  data_src_mem;
  logic  mark_dirty;
  logic  lru_update;
  logic  word_clear;
  logic  word_inc;
  logic  spill_sel;
  logic  flush_clear;
  logic  flush_inc;
  logic  victim_load;

  // Status
  logic  hit;
  logic  victim_dirty;
  logic  word_last;
  logic  flush_set_last;
  word_t rd_word;

  cache_ctrl u_ctrl (.*);

  cache_dpath u_dpath (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_addr       (req_addr),
    .req_data       (req_data),
    .mem_resp_data  (mem_resp_data),
    .req_load       (req_load),
    .tag_wen        (tag_wen),
    .data_wen       (data_wen),
    .data_src_mem   (data_src_mem),
    .mark_dirty     (mark_dirty),
    .lru_update     (lru_update),
    .word_clear     (word_clear),
    .word_inc       (word_inc),
    .spill_sel      (spill_sel),
    .flush_clear    (flush_clear),
    .flush_inc      (flush_inc),
    .victim_load    (victim_load),
    .resp_data      (rd_word),
    .mem_req_addr   (mem_req_addr),
    .mem_req_data   (mem_req_data),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .word_last      (word_last),
    .flush_set_last (flush_set_last)
  );

  // Write responses carry no data
  assign resp_data = resp_write ? '0 : rd_word;

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
// Cache controller
// FSM for lookup, spill, refill and flush; drives all handshakes and datapath controls

`default_nettype none

module cache_ctrl
  import cache_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic req_val,
  input  logic req_write,
  input  logic resp_rdy,
  input  logic mem_req_rdy,
  input  logic mem_resp_val,
  input  logic flush,
  input  logic hit,
  input  logic victim_dirty,
  input  logic word_last,
  input  logic flush_set_last,
  output logic req_rdy,
  output logic resp_val,
  output logic resp_write,
  output logic mem_req_val,
  output logic mem_req_write,
  output logic mem_resp_rdy,
  output logic flush_done,
  output logic req_load,
  output logic tag_wen,
  output logic data_wen,
  output logic data_src_mem,
  output logic mark_dirty,
  output logic lru_update,
  output logic word_clear,
  output logic word_inc,
  output logic spill_sel,
  output logic flush_clear,
  output logic flush_inc,
  output logic victim_load
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        write_q;
  logic        st_spill;
  logic        st_wait;

  // ============================================================
  // State register
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (req_load) begin
      write_q <= req_write;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // Flush wins over a pending request
        if (flush) begin
          state_next = FLUSH_SCAN;
        end else if (req_val) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_next = RESPOND;
        end else if (victim_dirty) begin
          state_next = SPILL_REQ;
        end else begin
          state_next = REFILL_REQ;
        end
      end
      RESPOND:     if (resp_rdy) state_next = IDLE;
      SPILL_REQ:   if (mem_req_rdy) state_next = SPILL_WAIT;
      SPILL_WAIT: begin
        if (mem_resp_val) begin
          state_next = word_last ? REFILL_REQ : SPILL_REQ;
        end
      end
      REFILL_REQ:  if (mem_req_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT: begin
        if (mem_resp_val) begin
          state_next = word_last ? REFILL_DONE : REFILL_REQ;
        end
      end
      REFILL_DONE: state_next = RESPOND;
      FLUSH_SCAN: begin
        if (victim_dirty) begin
          state_next = FLUSH_SPILL_REQ;
        end else if (flush_set_last) begin
          state_next = FLUSH_DONE;
        end
      end
      FLUSH_SPILL_REQ: if (mem_req_rdy) state_next = FLUSH_SPILL_WAIT;
      FLUSH_SPILL_WAIT: begin
        if (mem_resp_val && word_last) begin
          state_next = flush_set_last ? FLUSH_DONE : FLUSH_SCAN;
        end else if (mem_resp_val) begin
          state_next = FLUSH_SPILL_REQ;
        end
      end
      FLUSH_DONE:  state_next = IDLE;
      default:     state_next = IDLE;
    endcase
  end

  // ============================================================
  // Handshake outputs
  // ============================================================
  assign st_spill = (state == SPILL_REQ) || (state == SPILL_WAIT) ||
                    (state == FLUSH_SPILL_REQ) || (state == FLUSH_SPILL_WAIT);
  assign st_wait  = (state == SPILL_WAIT) || (state == REFILL_WAIT) ||
                    (state == FLUSH_SPILL_WAIT);

  assign req_rdy       = (state == IDLE) && !flush;
  assign resp_val      = (state == RESPOND);
  assign resp_write    = write_q;
  assign mem_req_val   = (state == SPILL_REQ) || (state == REFILL_REQ) ||
                         (state == FLUSH_SPILL_REQ);
  assign mem_req_write = (state == SPILL_REQ) || (state == FLUSH_SPILL_REQ);
  assign mem_resp_rdy  = st_wait;
  assign flush_done    = (state == FLUSH_DONE);

  // Datapath controls
  assign req_load     = req_rdy && req_val;
  assign flush_clear  = (state == IDLE) && flush;
  assign victim_load  = (state == LOOKUP);
  assign word_clear   = (state == LOOKUP) || (state == FLUSH_SCAN);
  assign word_inc     = st_wait && mem_resp_val;
  // Miss in lookup already starts reading word 0 of the victim
  assign spill_sel    = ((state == LOOKUP) && !hit) || (state == FLUSH_SCAN) || st_spill;
  assign data_src_mem = (state == REFILL_REQ) || (state == REFILL_WAIT);
  assign tag_wen      = (state == REFILL_DONE);
  assign mark_dirty   = write_q && (((state == LOOKUP) && hit) || (state == REFILL_DONE));
  assign data_wen     = mark_dirty || ((state == REFILL_WAIT) && mem_resp_val);
  assign lru_update   = ((state == LOOKUP) && hit) || (state == REFILL_DONE);
  assign flush_inc    = ((state == FLUSH_SCAN) && !victim_dirty) ||
                        ((state == FLUSH_SPILL_WAIT) && mem_resp_val && word_last);

endmodule

`default_nettype wire

/* hw/cache_data_array.sv */
// Cache data array
// Line storage for both ways, one word written per edge, registered word read

`default_nettype none

module cache_data_array
  import cache_pkg::*;
(
  input  logic  clk,
  input  idx_t  idx,
  input  logic  way,
  input  off_t  off,
  input  logic  wen,
  input  word_t wdata,
  output word_t rdata
);

  localparam int DEPTH = NUM_WAYS * NUM_SETS * LINE_WORDS;

  word_t                    mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] addr;

  // Word address is way, then set, then offset
  assign addr = {way, idx, off};

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= wdata;
    end
  end

  // Old contents come back when the same word is written on this edge
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* hw/cache_dpath.sv */
// Cache datapath
// Request registers, word and flush counters, way select, arrays and memory address

`default_nettype none

module cache_dpath
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  addr_t req_addr,
  input  word_t req_data,
  input  word_t mem_resp_data,
  input  logic  req_load,
  input  logic  tag_wen,
  input  logic  data_wen,
  input  logic  data_src_mem,
  input  logic  mark_dirty,
  input  logic  lru_update,
  input  logic  word_clear,
  input  logic  word_inc,
  input  logic  spill_sel,
  input  logic  flush_clear,
  input  logic  flush_inc,
  input  logic  victim_load,
  output word_t resp_data,
  output addr_t mem_req_addr,
  output word_t mem_req_data,
  output logic  hit,
  output logic  victim_dirty,
  output logic  word_last,
  output logic  flush_set_last
);

  tag_t                   tag_q;
  idx_t                   idx_q;
  off_t                   off_q;
  word_t                  data_q;
  off_t                   word_cnt;
  off_t                   word_cnt_next;
  logic [FLUSH_CNT_W-1:0] flush_cnt;
  logic [FLUSH_CNT_W-1:0] flush_cnt_next;
  logic                   flush_mode;
  logic                   flush_mode_next;
  logic                   way_q;
  logic                   way_cur;
  idx_t                   idx_cur;
  idx_t                   rd_idx;
  logic                   hit_way;
  logic                   victim_way;
  tag_t                   victim_tag;
  off_t                   data_off;
  word_t                  data_wdata;
  word_t                  rdata;

  // ============================================================
  // Request and counters
  // ============================================================
  always_ff @(posedge clk) begin
    if (req_load) begin
      tag_q  <= req_addr[TAG_MSB:TAG_LSB];
      idx_q  <= req_addr[IDX_MSB:IDX_LSB];
      off_q  <= req_addr[OFF_MSB:OFF_LSB];
      data_q <= req_data;
    end
  end

  assign word_cnt_next   = word_clear ? '0 : (word_inc ? word_cnt + 2'd1 : word_cnt);
  assign flush_cnt_next  = flush_clear ? '0 : (flush_inc ? flush_cnt + 1'b1 : flush_cnt);
  assign flush_mode_next = flush_clear ? 1'b1 : (req_load ? 1'b0 : flush_mode);

  always_ff @(posedge clk) begin
    word_cnt   <= word_cnt_next;
    flush_cnt  <= flush_cnt_next;
    flush_mode <= flush_mode_next;
    if (victim_load) begin
      way_q <= way_cur;
    end
  end

  assign word_last      = (word_cnt == off_t'(LINE_WORDS - 1));
  assign flush_set_last = &flush_cnt;

  // Hit way or victim during lookup, flush way during a flush walk
  assign way_cur = victim_load ? (hit ? hit_way : victim_way)
                               : (flush_mode ? flush_cnt[0] : way_q);
  assign idx_cur = flush_mode ? flush_cnt[FLUSH_CNT_W-1:1] : idx_q;

  // Tags are read one edge ahead of the set they describe
  assign rd_idx = req_load ? req_addr[IDX_MSB:IDX_LSB]
                           : (flush_mode_next ? flush_cnt_next[FLUSH_CNT_W-1:1] : idx_q);

  // ============================================================
  // Arrays
  // ============================================================
  cache_tag_array u_tag_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_idx       (rd_idx),
    .wr_idx       (idx_cur),
    .wr_way       (way_cur),
    .tag_wen      (tag_wen),
    .wr_tag       (tag_q),
    .mark_dirty   (mark_dirty),
    .clear_dirty  (flush_inc),
    .lru_update   (lru_update),
    .lru_way      (way_cur),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_tag   (victim_tag),
    .victim_dirty (victim_dirty)
  );

  // Spill reads run one word ahead so the word is ready with the request
  assign data_off   = spill_sel ? word_cnt_next : (data_src_mem ? word_cnt : off_q);
  assign data_wdata = data_src_mem ? mem_resp_data : data_q;

  cache_data_array u_data_array (
    .clk   (clk),
    .idx   (idx_cur),
    .way   (way_cur),
    .off   (data_off),
    .wen   (data_wen),
    .wdata (data_wdata),
    .rdata (rdata)
  );

  assign resp_data    = rdata;
  assign mem_req_data = rdata;
  assign mem_req_addr = {(spill_sel ? victim_tag : tag_q), idx_cur, word_cnt, 2'b00};

endmodule

`default_nettype wire

/* hw/cache_pkg.sv */
// Cache package
// Geometry, address split, vector types and controller states shared by the cache RTL

`default_nettype none

package cache_pkg;

  // ============================================================
  // Geometry
  // ============================================================
  localparam int NUM_SETS    = 8;
  localparam int NUM_WAYS    = 2;
  localparam int LINE_WORDS  = 4;
  localparam int FLUSH_CNT_W = 4;

  // Address split: [31:7] tag, [6:4] index, [3:2] word offset
  localparam int OFF_LSB = 2;
  localparam int OFF_MSB = 3;
  localparam int IDX_LSB = 4;
  localparam int IDX_MSB = 6;
  localparam int TAG_LSB = 7;
  localparam int TAG_MSB = 31;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [24:0] tag_t;
  typedef logic [2:0]  idx_t;
  typedef logic [1:0]  off_t;

  typedef enum logic [3:0] {
    IDLE,
    LOOKUP,
    RESPOND,
    SPILL_REQ,
    SPILL_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_DONE,
    FLUSH_SCAN,
    FLUSH_SPILL_REQ,
    FLUSH_SPILL_WAIT,
    FLUSH_DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/cache_tag_array.sv */
// Cache tag array
// Tags, valid and dirty bits per way, one LRU bit per set, tag compare and victim choice

`default_nettype none

module cache_tag_array
  import cache_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  idx_t rd_idx,
  input  idx_t wr_idx,
  input  logic wr_way,
  input  logic tag_wen,
  input  tag_t wr_tag,
  input  logic mark_dirty,
  input  logic clear_dirty,
  input  logic lru_update,
  input  logic lru_way,
  output logic hit,
  output logic hit_way,
  output logic victim_way,
  output tag_t victim_tag,
  output logic victim_dirty
);

  tag_t                tags     [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid    [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty    [NUM_WAYS];
  logic [NUM_SETS-1:0] lru;

  tag_t                rd_tag   [NUM_WAYS];
  logic [NUM_WAYS-1:0] rd_valid;
  logic [NUM_WAYS-1:0] rd_dirty;
  logic                rd_lru;
  logic [NUM_WAYS-1:0] way_hit;

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tags[wr_way][wr_idx] <= wr_tag;
    end
  end

  // Status bits; a refill installs the line clean, a write hit then dirties it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
      lru <= '0;
    end else begin
      if (tag_wen) begin
        valid[wr_way][wr_idx] <= 1'b1;
        dirty[wr_way][wr_idx] <= 1'b0;
      end
      if (clear_dirty) begin
        dirty[wr_way][wr_idx] <= 1'b0;
      end
      if (mark_dirty) begin
        dirty[wr_way][wr_idx] <= 1'b1;
      end
      if (lru_update) begin
        lru[wr_idx] <= ~lru_way;
      end
    end
  end

  // One-cycle read of both ways
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_tag[w]   <= tags[w][rd_idx];
      rd_valid[w] <= valid[w][rd_idx];
      rd_dirty[w] <= dirty[w][rd_idx];
    end
    rd_lru <= lru[rd_idx];
  end

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = rd_valid[w] && (rd_tag[w] == wr_tag);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  // Invalid way first (way 0 before way 1), otherwise LRU
  assign victim_way = !rd_valid[0] ? 1'b0 : (!rd_valid[1] ? 1'b1 : rd_lru);

  // Tag and dirty bit of the way being addressed
  assign victim_tag   = rd_tag[wr_way];
  assign victim_dirty = rd_dirty[wr_way];

endmodule

`default_nettype wire

/* project.f */
hw/cache_pkg.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/cache_dpath.sv
hw/cache_ctrl.sv
hw/cache_alt.sv
verification/cache_alt_chk.sv
verification/cache_alt_tb.sv

/* verification/cache_alt_chk.sv */
// Cache protocol checker
// Handshake stability, one request in flight, no memory traffic on a hit, flush pulse

`default_nettype none

module cache_alt_chk
  import cache_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input ctrl_state_t state,
  input logic        req_val,
  input logic        req_rdy,
  input logic        req_write,
  input logic        resp_val,
  input logic        resp_rdy,
  input logic        resp_write,
  input logic        mem_req_val,
  input logic        mem_req_rdy,
  input logic        mem_req_write,
  input logic        mem_resp_val,
  input logic        mem_resp_rdy,
  input logic        hit,
  input logic        flush,
  input logic        flush_done
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count;
  logic        busy;

  initial begin
    fail_count = 0;
  end

  // Busy from an accepted request or a flush start until its response or flush_done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if ((resp_val && resp_rdy) || flush_done) begin
      busy <= 1'b0;
    end else if ((req_val && req_rdy) || flush) begin
      busy <= 1'b1;
    end
  end

  // ============================================================
  // Handshakes hold until the transfer
  // ============================================================
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_val && !req_rdy |=> req_val && $stable(req_write))
    else begin
      fail_count++;
      $error("Processor request dropped or changed before it was accepted");
    end

  resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_write))
    else begin
      fail_count++;
      $error("Processor response dropped or changed before it was taken");
    end

  mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_write))
    else begin
      fail_count++;
      $error("Memory request dropped or changed before it was accepted");
    end

  mem_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_resp_val && !mem_resp_rdy |=> mem_resp_val)
    else begin
      fail_count++;
      $error("Memory response dropped before the cache took it");
    end

  // ============================================================
  // Controller protocol
  // ============================================================
  rdy_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !req_rdy)
    else begin
      fail_count++;
      $error("req_rdy was high while a request or a flush was in progress");
    end

  hit_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
    (state == LOOKUP) && hit |=> (state == RESPOND) && !mem_req_val)
    else begin
      fail_count++;
      $error("A hit did not go straight to RESPOND without memory traffic");
    end

  flush_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    flush_done |=> !flush_done)
    else begin
      fail_count++;
      $error("flush_done stayed high for more than one cycle");
    end

endmodule

`default_nettype wire

/* verification/cache_alt_tb.sv */
// Cache testbench
// Drives the two-way cache against a stalling memory model and a reference word map

`default_nettype none

module cache_alt_tb
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED         = 32'hadfd_ec13;
  localparam word_t       INIT_KEY     = 32'h5ca1_ab1e;
  localparam int          BP_OPS       = 40;
  localparam int          FLUSH_WRITES = 24;
  localparam int          MIX_OPS      = 300;
  // Directed tests and the flush walk count as about 70 operations
  localparam int          TOTAL_OPS      = 70 + BP_OPS + FLUSH_WRITES + MIX_OPS;
  localparam int          TIMEOUT_CYCLES = TOTAL_OPS * 40 + 1000;

  logic  clk;
  logic  rst_n;
  logic  req_val;
  logic  req_rdy;
  logic  req_write;
  addr_t req_addr;
  word_t req_data;
  logic  resp_val;
  logic  resp_rdy;
  logic  resp_write;
  word_t resp_data;
  logic  mem_req_val;
  logic  mem_req_rdy;
  logic  mem_req_write;
  addr_t mem_req_addr;
  word_t mem_req_data;
  logic  mem_resp_val;
  logic  mem_resp_rdy;
  word_t mem_resp_data;
  logic  flush;
  logic  flush_done;

  word_t       shadow [addr_t];
  word_t       mem_model [addr_t];
  logic        exp_write_q [$];
  word_t       exp_data_q [$];
  addr_t       exp_addr_q [$];
  string       exp_name_q [$];
  addr_t       wb_addr_q [$];
  word_t       wb_data_q [$];
  int unsigned mem_req_count;
  int unsigned cycle;
  int unsigned accept_cycle;
  int unsigned resp_cycle;
  logic        bp_en;
  int          err_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;
  string       cur_test;

  cache_alt u_cache_alt (.*);

  bind cache_ctrl cache_alt_chk u_chk (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ============================================================
  // Reference model
  // ============================================================
  // Initial memory pattern over the whole address
  function automatic word_t init_word(input addr_t a);
    return a ^ INIT_KEY;
  endfunction

  function automatic word_t ref_peek(input addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return init_word(a);
  endfunction

  // Last value written, else the pattern; a write answers zero
  function automatic word_t ref_access(input logic write, input addr_t a, input word_t d);
    if (write) begin
      shadow[a] = d;
      return '0;
    end
    return ref_peek(a);
  endfunction

  function automatic word_t mem_peek(input addr_t a);
    if (mem_model.exists(a)) begin
      return mem_model[a];
    end
    return init_word(a);
  endfunction

  function automatic int total_errors();
    return err_count + int'(u_cache_alt.u_ctrl.u_chk.fail_count);
  endfunction

  task automatic check_value(input string name, input string what,
                             input word_t exp, input word_t act);
    check_count++;
    assert (act === exp) else begin
      err_count++;
      $display("Mismatch in %s: %s expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // ============================================================
  // Memory model with random stalls
  // ============================================================
  initial begin : memory_model
    word_t rd;
    int    delay;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    forever begin
      @(posedge clk);
      if (rst_n && mem_req_val && mem_req_rdy) begin
        mem_req_count++;
        if (mem_req_write) begin
          mem_model[mem_req_addr] = mem_req_data;
          wb_addr_q.push_back(mem_req_addr);
          wb_data_q.push_back(mem_req_data);
          rd = '0;
        end else begin
          if (!mem_model.exists(mem_req_addr)) begin
            mem_model[mem_req_addr] = init_word(mem_req_addr);
          end
          rd = mem_model[mem_req_addr];
        end
        delay = $urandom % 3;
        #1;
        mem_req_rdy = 1'b0;
        repeat (delay) @(posedge clk);
        if (delay != 0) begin
          #1;
        end
        mem_resp_val  = 1'b1;
        mem_resp_data = rd;
        @(posedge clk);
        while (!mem_resp_rdy) begin
          @(posedge clk);
        end
        #1;
        mem_resp_val = 1'b0;
        mem_req_rdy  = ($urandom % 4) != 0;
      end else begin
        #1;
        mem_req_rdy = ($urandom % 4) != 0;
      end
    end
  end

  // Response back-pressure when enabled
  always @(posedge clk) begin
    #1;
    resp_rdy = bp_en ? (($urandom % 2) == 0) : 1'b1;
  end

  // ============================================================
  // Response comparison
  // ============================================================
  always @(posedge clk) begin : compare
    string name;
    addr_t a;
    if (rst_n && resp_val && resp_rdy) begin
      resp_cycle = cycle;
      assert (exp_data_q.size() != 0) else begin
        err_count++;
        $display("Response arrived with no request outstanding");
      end
      if (exp_data_q.size() != 0) begin
        name = exp_name_q.pop_front();
        a    = exp_addr_q.pop_front();
        check_value(name, $sformatf("resp_write at %h", a),
                    word_t'(exp_write_q.pop_front()), word_t'(resp_write));
        check_value(name, $sformatf("resp_data at %h", a), exp_data_q.pop_front(), resp_data);
      end
    end
  end

  // ============================================================
  // Stimulus tasks
  // ============================================================
  task automatic issue(input string name, input logic write, input addr_t a, input word_t d);
    exp_write_q.push_back(write);
    exp_data_q.push_back(ref_access(write, a, d));
    exp_addr_q.push_back(a);
    exp_name_q.push_back(name);
    req_val   = 1'b1;
    req_write = write;
    req_addr  = a;
    req_data  = d;
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    accept_cycle = cycle;
    #1;
    req_val = 1'b0;
  endtask

  task automatic drain();
    while (exp_data_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_random(input string name, input int n, input addr_t base, input int words);
    addr_t a;
    logic  w;
    for (int i = 0; i < n; i++) begin
      a = base + addr_t'(($urandom % words) * 4);
      w = ($urandom % 2) == 0;
      issue(name, w, a, $urandom);
    end
  endtask

  task automatic run_flush();
    flush = 1'b1;
    @(posedge clk);
    while (!flush_done) begin
      @(posedge clk);
    end
    #1;
    flush = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = total_errors();
  endtask

  task automatic finish_test();
    drain();
    tests_run++;
    if (total_errors() == test_err_start) begin
      $display("Test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", cur_test, total_errors() - test_err_start);
    end
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin : main_seq
    addr_t       a;
    addr_t       last_addr;
    addr_t       b_line;
    int unsigned mem_before;
    clk           = 1'b0;
    rst_n         = 1'b0;
    req_val       = 1'b0;
    req_write     = 1'b0;
    req_addr      = '0;
    req_data      = '0;
    resp_rdy      = 1'b0;
    flush         = 1'b0;
    bp_en         = 1'b0;
    cycle         = 0;
    mem_req_count = 0;
    err_count     = 0;
    check_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    void'($urandom(SEED));
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("read_after_write");
    issue(cur_test, 1'b1, 32'h0000_0100, 32'h1111_0100);
    issue(cur_test, 1'b1, 32'h0000_0104, 32'h1111_0104);
    issue(cur_test, 1'b1, 32'h0000_0114, 32'h1111_0114);
    issue(cur_test, 1'b0, 32'h0000_0100, '0);
    issue(cur_test, 1'b0, 32'h0000_0104, '0);
    issue(cur_test, 1'b0, 32'h0000_0108, '0);
    // Two more tags in set 0 push the first dirty line out
    issue(cur_test, 1'b1, 32'h0000_0180, 32'h2222_0180);
    issue(cur_test, 1'b1, 32'h0000_0200, 32'h3333_0200);
    issue(cur_test, 1'b0, 32'h0000_0100, '0);
    issue(cur_test, 1'b0, 32'h0000_0180, '0);
    finish_test();

    start_test("hit_latency");
    for (int i = 0; i < 3; i++) begin
      a = 32'h0000_0110 + addr_t'(i * 4);
      issue(cur_test, 1'b0, a, '0);
      drain();
      mem_before = mem_req_count;
      issue(cur_test, 1'b0, a, '0);
      drain();
      check_value(cur_test, "hit latency", 32'd2, word_t'(resp_cycle - accept_cycle));
      check_value(cur_test, "memory requests on hit", '0, word_t'(mem_req_count - mem_before));
    end
    finish_test();

    // Set 2 is still empty: A lands in way 0, B in way 1, the hit on A leaves B as LRU
    start_test("lru_eviction");
    issue(cur_test, 1'b1, 32'h0000_0420, 32'haaaa_0420);
    issue(cur_test, 1'b1, 32'h0000_04a4, 32'hbbbb_04a4);
    issue(cur_test, 1'b0, 32'h0000_0420, '0);
    drain();
    wb_addr_q.delete();
    wb_data_q.delete();
    b_line = 32'h0000_04a0;
    issue(cur_test, 1'b1, 32'h0000_0528, 32'hcccc_0528);
    drain();
    check_value(cur_test, "write-back count", 32'd4, word_t'(wb_addr_q.size()));
    for (int i = 0; i < 4 && i < wb_addr_q.size(); i++) begin
      a = b_line + addr_t'(i * 4);
      check_value(cur_test, "write-back address", a, wb_addr_q[i]);
      check_value(cur_test, "write-back data", ref_peek(a), wb_data_q[i]);
      check_value(cur_test, $sformatf("memory at %h", a), ref_peek(a), mem_peek(a));
    end
    issue(cur_test, 1'b0, 32'h0000_04a4, '0);
    finish_test();

    bp_en = 1'b1;
    start_test("back_pressure");
    run_random(cur_test, BP_OPS, 32'h0000_0800, 64);
    finish_test();

    start_test("flush");
    last_addr = '0;
    for (int i = 0; i < FLUSH_WRITES; i++) begin
      last_addr = 32'h0000_3000 + addr_t'(($urandom % 128) * 4);
      issue(cur_test, 1'b1, last_addr, $urandom);
    end
    drain();
    run_flush();
    foreach (shadow[k]) begin
      check_value(cur_test, $sformatf("memory at %h", k), shadow[k], mem_peek(k));
    end
    mem_before = mem_req_count;
    issue(cur_test, 1'b0, last_addr, '0);
    drain();
    check_value(cur_test, "memory requests on re-read", '0,
                word_t'(mem_req_count - mem_before));
    finish_test();

    start_test("random_mix");
    run_random(cur_test, MIX_OPS, 32'h0000_2000, 512);
    finish_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, total_errors());
    if (total_errors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
